// ==== Makefile ====
# Verilator build and run for the instruction prefetch testbench
VERILATOR ?= verilator
TOP       ?= tb_axil_fetch
FILELIST  ?= fetch.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "sim passed" $(LOG) || (echo "FAILED: see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== fetch.f ====
verilog/fetch_pkg.sv
verilog/fetch_request_ctrl.sv
verilog/bus_credit_counter.sv
verilog/insn_fifo.sv
verilog/insn_unpacker.sv
verilog/axil_fetch.sv
testbench/fetch_checker.sv
testbench/tb_axil_fetch.sv

// ==== testbench/fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker #(
	parameter int ADDR_WIDTH = 32,
	parameter int INSN_WIDTH = 32,
	parameter int BUS_WIDTH = 64,
	parameter int FETCH_LIMIT = 16,
	parameter logic [31:0] MEM_XOR = 32'h5a5a_0000,
	parameter logic [31:0] ERR_LO = 32'h1200,
	parameter logic [31:0] ERR_HI = 32'h1240
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  fifo_reset,
	input  logic                  i_new_pc,
	input  logic                  i_clear_cache,
	input  logic                  i_ready,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic [INSN_WIDTH-1:0] i_insn,
	input  logic [ADDR_WIDTH-1:0] i_out_pc,
	input  logic                  i_valid,
	input  logic                  i_illegal,
	input  logic                  i_arvalid,
	input  logic                  i_arready,
	input  logic [ADDR_WIDTH-1:0] i_araddr,
	input  logic [2:0]            i_arprot,
	input  logic                  i_rvalid,
	input  logic                  i_rready,
	output int                    o_errors
);

	// Unprivileged, secure, instruction access
	localparam logic [2:0] EXP_ARPROT = 3'b100;

	logic [ADDR_WIDTH-1:0] exp_pc;
	logic                  exp_known;
	logic                  restart_q;
	logic                  hold_q;
	logic                  stick_q;
	logic                  ar_stall_q;
	logic [INSN_WIDTH-1:0] insn_q;
	logic [ADDR_WIDTH-1:0] pc_q;
	logic                  illegal_q;
	logic [ADDR_WIDTH-1:0] araddr_q;
	int                    outstanding;
	int                    stale;

	task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] got);
		$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, got);
		o_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t: %s", $time, what);
		o_errors++;
	endtask

	// Bus words that the slave answers with an error
	function automatic logic in_error_window(input logic [ADDR_WIDTH-1:0] addr);
		logic [ADDR_WIDTH-1:0] word;
		word = addr & ~ADDR_WIDTH'(BUS_WIDTH/8 - 1);
		return (word >= ERR_LO) && (word < ERR_HI);
	endfunction

	initial
	begin
		o_errors = 0;
		exp_known = 1'b0;
		exp_pc = '0;
	end

	always @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			exp_known = 1'b0;
			outstanding = 0;
			stale = 0;
			restart_q <= 1'b0;
			hold_q <= 1'b0;
			stick_q <= 1'b0;
			ar_stall_q <= 1'b0;
		end
		else
		begin
			if (restart_q && i_valid)
				report_problem("o_valid high in the cycle after a redirect or clear");

			// Stalled output must not move
			if (hold_q)
			begin
				if (i_insn !== insn_q)
					report_value("o_insn", 64'(insn_q), 64'(i_insn));
				if (i_out_pc !== pc_q)
					report_value("o_pc", 64'(pc_q), 64'(i_out_pc));
				if (i_illegal !== illegal_q)
					report_value("o_illegal", 64'(illegal_q), 64'(i_illegal));
			end
			if (stick_q && !i_illegal)
				report_problem("o_illegal dropped without a redirect or clear");
			if (stick_q && (i_out_pc !== pc_q))
				report_value("o_pc", 64'(pc_q), 64'(i_out_pc));

			if (i_illegal && !i_valid)
				report_problem("o_illegal high while o_valid is low");
			if (i_illegal && i_valid && !in_error_window(i_out_pc))
				report_problem("o_illegal raised outside the error window");
			if (i_illegal && i_valid && exp_known && (i_out_pc !== exp_pc))
				report_value("o_pc", 64'(exp_pc), 64'(i_out_pc));

			// Accepted instruction
			if (i_valid && i_ready && !i_illegal)
			begin
				if (!exp_known)
					report_problem("instruction handed out before any redirect");
				else
				begin
					if (i_out_pc !== exp_pc)
						report_value("o_pc", 64'(exp_pc), 64'(i_out_pc));
					if (i_insn !== INSN_WIDTH'(exp_pc ^ MEM_XOR))
						report_value("o_insn", 64'(exp_pc ^ MEM_XOR), 64'(i_insn));
				end
				exp_pc = exp_pc + 4;
			end
			if (i_new_pc)
			begin
				exp_pc = i_pc;
				exp_known = 1'b1;
			end

			if (ar_stall_q && !i_arvalid)
				report_problem("o_axi_arvalid dropped while AR was stalled");
			else if (ar_stall_q && (i_araddr !== araddr_q))
				report_value("o_axi_araddr", 64'(araddr_q), 64'(i_araddr));

			// Constant AR and R channel controls
			if (i_arprot !== EXP_ARPROT)
				report_value("o_axi_arprot", 64'(EXP_ARPROT), 64'(i_arprot));
			if (i_rready !== 1'b1)
				report_value("o_axi_rready", 64'(1'b1), 64'(i_rready));

			///////////////////////////////////////////////////////////////////
			// Reads in flight, split into flushed and current
			///////////////////////////////////////////////////////////////////
			if (i_new_pc || i_clear_cache)
				stale = outstanding + int'(i_arvalid) - int'(i_rvalid);
			else if (i_rvalid && (stale > 0))
				stale = stale - 1;
			outstanding = outstanding + int'(i_arvalid && i_arready) - int'(i_rvalid);
			if (outstanding < 0)
				report_problem("read response without an outstanding request");
			if ((outstanding - stale) > FETCH_LIMIT)
				report_value("outstanding reads", 64'(FETCH_LIMIT), 64'(outstanding - stale));

			restart_q <= i_new_pc || i_clear_cache;
			hold_q <= i_valid && !i_ready && !i_new_pc && !i_clear_cache;
			stick_q <= i_illegal && !i_new_pc && !i_clear_cache;
			ar_stall_q <= i_arvalid && !i_arready;
		end
		insn_q <= i_insn;
		pc_q <= i_out_pc;
		illegal_q <= i_illegal;
		araddr_q <= i_araddr;
	end

endmodule

// ==== testbench/tb_axil_fetch.sv ====
`timescale 1ns/1ps

module tb_axil_fetch;

	localparam int ADDR_WIDTH = 32;
	localparam int BUS_WIDTH = 64;
	localparam int INSN_WIDTH = 32;
	localparam int FETCH_LIMIT = 16;
	localparam int NUM_CYCLES = 4000;
	localparam longint WATCHDOG_NS = longint'(NUM_CYCLES) * 40 * 4;
	localparam logic [31:0] MEM_XOR = 32'h5a5a_0000;
	localparam logic [31:0] ERR_LO = 32'h1200;
	localparam logic [31:0] ERR_HI = 32'h1240;

	logic                  S_AXI_ACLK;
	logic                  fifo_reset;
	logic                  i_new_pc;
	logic                  i_clear_cache;
	logic                  i_ready;
	logic [ADDR_WIDTH-1:0] i_pc;
	logic                  i_axi_arready;
	logic                  i_axi_rvalid;
	logic [BUS_WIDTH-1:0]  i_axi_rdata;
	logic [1:0]            i_axi_rresp;
	logic [INSN_WIDTH-1:0] o_insn;
	logic [ADDR_WIDTH-1:0] o_pc;
	logic                  o_valid;
	logic                  o_illegal;
	logic                  o_axi_arvalid;
	logic [ADDR_WIDTH-1:0] o_axi_araddr;
	logic [2:0]            o_axi_arprot;
	logic                  o_axi_rready;

	logic [31:0]           seed;
	logic [31:0]           r1;
	logic [31:0]           r2;
	logic [ADDR_WIDTH-1:0] addr_q[$];
	logic [ADDR_WIDTH-1:0] rd_addr;
	int                    delay;
	int                    cycle;
	int                    check_errors;
	int                    drain_errors;
	logic                  drained;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Each slot holds its own byte address XOR a constant
	function automatic logic [BUS_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] addr);
		logic [ADDR_WIDTH-1:0] base;
		logic [BUS_WIDTH-1:0]  word;
		base = addr & ~ADDR_WIDTH'(BUS_WIDTH/8 - 1);
		word = '0;
		for (int k = 0; k < BUS_WIDTH/INSN_WIDTH; k++)
			word[k*INSN_WIDTH +: INSN_WIDTH] = INSN_WIDTH'((base + 4*k) ^ MEM_XOR);
		return word;
	endfunction

	function automatic logic in_error_window(input logic [ADDR_WIDTH-1:0] addr);
		logic [ADDR_WIDTH-1:0] base;
		base = addr & ~ADDR_WIDTH'(BUS_WIDTH/8 - 1);
		return (base >= ERR_LO) && (base < ERR_HI);
	endfunction

	axil_fetch #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.BUS_WIDTH   (BUS_WIDTH),
		.INSN_WIDTH  (INSN_WIDTH),
		.FETCH_LIMIT (FETCH_LIMIT)
	) dut_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_clear_cache (i_clear_cache),
		.i_ready       (i_ready),
		.i_pc          (i_pc),
		.o_insn        (o_insn),
		.o_pc          (o_pc),
		.o_valid       (o_valid),
		.o_illegal     (o_illegal),
		.o_axi_arvalid (o_axi_arvalid),
		.i_axi_arready (i_axi_arready),
		.o_axi_araddr  (o_axi_araddr),
		.o_axi_arprot  (o_axi_arprot),
		.i_axi_rvalid  (i_axi_rvalid),
		.o_axi_rready  (o_axi_rready),
		.i_axi_rdata   (i_axi_rdata),
		.i_axi_rresp   (i_axi_rresp)
	);

	fetch_checker #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.INSN_WIDTH  (INSN_WIDTH),
		.BUS_WIDTH   (BUS_WIDTH),
		.FETCH_LIMIT (FETCH_LIMIT),
		.MEM_XOR     (MEM_XOR),
		.ERR_LO      (ERR_LO),
		.ERR_HI      (ERR_HI)
	) checker_i (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_clear_cache (i_clear_cache),
		.i_ready       (i_ready),
		.i_pc          (i_pc),
		.i_insn        (o_insn),
		.i_out_pc      (o_pc),
		.i_valid       (o_valid),
		.i_illegal     (o_illegal),
		.i_arvalid     (o_axi_arvalid),
		.i_arready     (i_axi_arready),
		.i_araddr      (o_axi_araddr),
		.i_arprot      (o_axi_arprot),
		.i_rvalid      (i_axi_rvalid),
		.i_rready      (o_axi_rready),
		.o_errors      (check_errors)
	);

	always #20 S_AXI_ACLK = ~S_AXI_ACLK;

	//////////////////////////////////////////////////////////////////////
	// CPU stimulus and AXI slave memory
	//////////////////////////////////////////////////////////////////////
	always @(posedge S_AXI_ACLK)
	begin
		r1 = lcg_next();
		r2 = lcg_next();
		if (fifo_reset)
		begin
			addr_q.delete();
			delay = 0;
			cycle = 0;
			i_axi_rvalid <= 1'b0;
		end
		else
		begin
			i_ready <= r1[31] | r1[30];
			i_axi_arready <= r1[29] | r1[28];
			i_pc <= 32'h1000 + {22'd0, r2[29:22], 2'b00};
			// Redirect right after reset, then now and then, sooner after an error
			if (cycle < NUM_CYCLES)
				i_new_pc <= (cycle == 0) || (r1[27:22] == 0) || (o_illegal && (r1[27:25] == 0));
			else
				i_new_pc <= 1'b0;
			i_clear_cache <= (cycle == NUM_CYCLES) || ((cycle < NUM_CYCLES) && (r1[21:14] == 0));

			if (o_axi_arvalid && i_axi_arready)
				addr_q.push_back(o_axi_araddr);
			i_axi_rvalid <= 1'b0;
			if ((addr_q.size() > 0) && (delay == 0))
			begin
				rd_addr = addr_q.pop_front();
				i_axi_rvalid <= 1'b1;
				i_axi_rdata <= in_error_window(rd_addr) ? '0 : word_at(rd_addr);
				i_axi_rresp <= in_error_window(rd_addr) ? 2'b10 : 2'b00;
				delay = int'(r2[31:30]);
			end
			else if (delay > 0)
				delay = delay - 1;
			cycle = cycle + 1;
		end
	end

	initial
	begin
		S_AXI_ACLK = 1'b0;
		seed = 32'hce75;
		fifo_reset = 1'b1;
		i_new_pc = 1'b0;
		i_clear_cache = 1'b0;
		i_ready = 1'b0;
		i_pc = '0;
		i_axi_arready = 1'b0;
		i_axi_rvalid = 1'b0;
		i_axi_rdata = '0;
		i_axi_rresp = 2'b00;
		drain_errors = 0;
		drained = 1'b0;
		cycle = 0;
		repeat (3) @(posedge S_AXI_ACLK);
		fifo_reset <= 1'b0;

		wait (cycle > NUM_CYCLES);
		// Wait for the bus to go quiet after the final clear
		for (int n = 0; (n < 1000) && !drained; n++)
		begin
			@(negedge S_AXI_ACLK);
			drained = (addr_q.size() == 0) && !o_axi_arvalid && !i_axi_rvalid;
		end
		if (!drained)
		begin
			$display("ERROR: read requests still pending long after the final clear");
			drain_errors++;
		end
		repeat (2) @(negedge S_AXI_ACLK);

		$display("errors: checker %0d, drain %0d", check_errors, drain_errors);
		if ((check_errors == 0) && (drain_errors == 0))
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired before the run finished");
		$display("sim failed");
		$finish;
	end

endmodule

// ==== verilog/axil_fetch.sv ====
`timescale 1ns/1ps

module axil_fetch #(
	parameter int ADDR_WIDTH = fetch_pkg::ADDR_WIDTH_DEF,
	parameter int BUS_WIDTH = fetch_pkg::BUS_WIDTH_DEF,
	parameter int INSN_WIDTH = fetch_pkg::INSN_WIDTH_DEF,
	parameter int FETCH_LIMIT = fetch_pkg::FETCH_LIMIT_DEF
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  fifo_reset,
	// CPU side
	input  logic                  i_new_pc,
	input  logic                  i_clear_cache,
	input  logic                  i_ready,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	output logic [INSN_WIDTH-1:0] o_insn,
	output logic [ADDR_WIDTH-1:0] o_pc,
	output logic                  o_valid,
	output logic                  o_illegal,
	// AXI-lite read channels
	output logic                  o_axi_arvalid,
	input  logic                  i_axi_arready,
	output logic [ADDR_WIDTH-1:0] o_axi_araddr,
	output logic [2:0]            o_axi_arprot,
	input  logic                  i_axi_rvalid,
	output logic                  o_axi_rready,
	input  logic [BUS_WIDTH-1:0]  i_axi_rdata,
	input  logic [1:0]            i_axi_rresp
);

	import fetch_pkg::*;

	logic                 restart;
	logic                 accept;
	logic                 bus_full;
	logic                 discarding;
	logic                 fifo_wr;
	logic                 fifo_rd;
	logic                 fifo_empty;
	logic [BUS_WIDTH:0]   fifo_data;

	assign o_axi_arprot = AR_PROT_INSN;
	assign o_axi_rready = 1'b1;

	// Responses of a flushed fetch never reach the FIFO
	assign fifo_wr = i_axi_rvalid && !discarding;

	fetch_request_ctrl #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.BUS_WIDTH   (BUS_WIDTH),
		.FETCH_LIMIT (FETCH_LIMIT)
	) u_request_ctrl (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.fifo_reset    (fifo_reset),
		.i_new_pc      (i_new_pc),
		.i_clear_cache (i_clear_cache),
		.i_pc          (i_pc),
		.i_arready     (i_axi_arready),
		.i_bus_full    (bus_full),
		.i_fifo_rd     (fifo_rd),
		.i_fifo_empty  (fifo_empty),
		.i_out_valid   (o_valid),
		.i_out_illegal (o_illegal),
		.i_ready       (i_ready),
		.o_arvalid     (o_axi_arvalid),
		.o_araddr      (o_axi_araddr),
		.o_restart     (restart),
		.o_accept      (accept)
	);

	bus_credit_counter #(
		.FETCH_LIMIT (FETCH_LIMIT)
	) u_credit_counter (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.fifo_reset   (fifo_reset),
		.i_restart    (restart),
		.i_accept     (accept),
		.i_arvalid    (o_axi_arvalid),
		.i_rvalid     (i_axi_rvalid),
		.o_bus_full   (bus_full),
		.o_discarding (discarding)
	);

	insn_fifo #(
		.BUS_WIDTH   (BUS_WIDTH),
		.FETCH_LIMIT (FETCH_LIMIT)
	) u_insn_fifo (
		.S_AXI_ACLK (S_AXI_ACLK),
		.i_restart  (restart),
		.i_wr       (fifo_wr),
		.i_data     ({i_axi_rresp[1], i_axi_rdata}),
		.i_rd       (fifo_rd),
		.o_data     (fifo_data),
		.o_empty    (fifo_empty)
	);

	insn_unpacker #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.BUS_WIDTH  (BUS_WIDTH),
		.INSN_WIDTH (INSN_WIDTH)
	) u_unpacker (
		.S_AXI_ACLK   (S_AXI_ACLK),
		.i_restart    (restart),
		.i_new_pc     (i_new_pc),
		.i_pc         (i_pc),
		.i_ready      (i_ready),
		.i_fifo_data  (fifo_data),
		.i_fifo_empty (fifo_empty),
		.o_fifo_rd    (fifo_rd),
		.o_insn       (o_insn),
		.o_pc         (o_pc),
		.o_valid      (o_valid),
		.o_illegal    (o_illegal)
	);

endmodule

// ==== verilog/bus_credit_counter.sv ====
`timescale 1ns/1ps

module bus_credit_counter #(
	parameter int FETCH_LIMIT = fetch_pkg::FETCH_LIMIT_DEF
) (
	input  logic S_AXI_ACLK,
	input  logic fifo_reset,
	input  logic i_restart,
	input  logic i_accept,
	input  logic i_arvalid,
	input  logic i_rvalid,
	output logic o_bus_full,
	output logic o_discarding
);

	localparam int CNT_W = $clog2(FETCH_LIMIT) + 4;
	// One below the top, so a request already on AR still fits
	localparam logic [CNT_W-1:0] FULL_AT = CNT_W'((1 << CNT_W) - 2);

	logic [CNT_W-1:0] outstanding;
	logic [CNT_W-1:0] next_outstanding;
	logic [CNT_W-1:0] discard_cnt;
	logic [CNT_W-1:0] new_discard;

	always_comb
	begin
		next_outstanding = outstanding;
		case ({i_accept, i_rvalid})
		2'b10: next_outstanding = outstanding + 1'b1;
		2'b01: next_outstanding = outstanding - 1'b1;
		default: begin end
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			outstanding <= '0;
			o_bus_full <= 1'b0;
		end
		else
		begin
			outstanding <= next_outstanding;
			o_bus_full <= (next_outstanding >= FULL_AT);
		end
	end

	// Everything in flight, plus the request on AR, belongs to the old stream
	assign new_discard = outstanding + CNT_W'(i_arvalid) - CNT_W'(i_rvalid);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			discard_cnt <= '0;
			o_discarding <= 1'b0;
		end
		else if (i_restart)
		begin
			discard_cnt <= new_discard;
			o_discarding <= (new_discard != '0);
		end
		else if (i_rvalid && (discard_cnt != '0))
		begin
			discard_cnt <= discard_cnt - 1'b1;
			o_discarding <= (discard_cnt > 1);
		end
	end

	// Slave never answers a read that was not asked for
	a_no_underflow: assert property (@(posedge S_AXI_ACLK) disable iff (fifo_reset)
		(i_rvalid && !i_accept) |-> (outstanding != '0))
		else $error("Read response with no read outstanding");

endmodule

// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

	// Default widths, overridden from the top level
	localparam int ADDR_WIDTH_DEF = 32;
	localparam int BUS_WIDTH_DEF = 64;
	localparam int INSN_WIDTH_DEF = 32;

	// Bus words fetched ahead, a power of two of at least 4
	localparam int FETCH_LIMIT_DEF = 16;

	// Unprivileged, secure, instruction access
	localparam logic [2:0] AR_PROT_INSN = 3'b100;

	// Request side of the fetch
	typedef enum logic [1:0]
	{
		REQ_IDLE,
		REQ_ISSUE,
		REQ_REDIRECT
	} req_state_t;

endpackage

// ==== verilog/fetch_request_ctrl.sv ====
`timescale 1ns/1ps

module fetch_request_ctrl #(
	parameter int ADDR_WIDTH = fetch_pkg::ADDR_WIDTH_DEF,
	parameter int BUS_WIDTH = fetch_pkg::BUS_WIDTH_DEF,
	parameter int FETCH_LIMIT = fetch_pkg::FETCH_LIMIT_DEF
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  fifo_reset,
	input  logic                  i_new_pc,
	input  logic                  i_clear_cache,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic                  i_arready,
	input  logic                  i_bus_full,
	input  logic                  i_fifo_rd,
	input  logic                  i_fifo_empty,
	input  logic                  i_out_valid,
	input  logic                  i_out_illegal,
	input  logic                  i_ready,
	output logic                  o_arvalid,
	output logic [ADDR_WIDTH-1:0] o_araddr,
	output logic                  o_restart,
	output logic                  o_accept
);

	import fetch_pkg::*;

	localparam int LANE_W = $clog2(BUS_WIDTH/8);
	localparam int CNT_W = $clog2(FETCH_LIMIT) + 4;
	localparam logic [CNT_W-1:0] FILL_MAX = CNT_W'(FETCH_LIMIT);

	req_state_t            state;
	logic [ADDR_WIDTH-1:0] pending_pc;
	logic [CNT_W-1:0]      fill;
	logic [CNT_W-1:0]      fill_est;
	logic                  fill_inc;
	logic                  fill_dec;
	logic                  ar_free;
	logic                  fill_stop;
	logic                  keep_issuing;

	assign o_restart = fifo_reset || i_clear_cache || i_new_pc;
	assign o_accept = o_arvalid && i_arready;
	assign ar_free = !o_arvalid || i_arready;

	//////////////////////////////////////////////////////////////////////
	// Fill count: words requested for the current stream, not yet read
	//////////////////////////////////////////////////////////////////////

	// A request left over from before a restart is not part of the stream
	assign fill_inc = o_accept && (state == REQ_ISSUE);
	assign fill_dec = i_fifo_rd && !i_fifo_empty;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_restart)
			fill <= '0;
		else if (fill_inc && !fill_dec)
			fill <= fill + 1'b1;
		else if (!fill_inc && fill_dec)
			fill <= fill - 1'b1;
	end

	// Leave room for a held output word that may still need a slot
	assign fill_est = fill + CNT_W'(o_accept) + CNT_W'(i_out_valid && !i_ready);
	assign fill_stop = (fill_est >= FILL_MAX);

	// A new burst starts only once the output stage has drained
	assign keep_issuing = (o_arvalid || !i_out_valid) && !i_out_illegal
		&& !i_bus_full && !fill_stop;

	//////////////////////////////////////////////////////////////////////
	// Request FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (fifo_reset)
		begin
			state <= REQ_IDLE;
			o_arvalid <= 1'b0;
		end
		else if (!ar_free)
		begin
			// AR stalled, the request on the channel stays put
			if (i_new_pc)
				state <= REQ_REDIRECT;
			else if (i_clear_cache)
				state <= REQ_IDLE;
		end
		else if (i_new_pc)
		begin
			state <= REQ_ISSUE;
			o_arvalid <= !i_bus_full;
		end
		else if (i_clear_cache)
		begin
			state <= REQ_IDLE;
			o_arvalid <= 1'b0;
		end
		else
		begin
			case (state)
			REQ_REDIRECT:
			begin
				// Stale request went out, now present the held PC
				state <= REQ_ISSUE;
				o_arvalid <= !i_bus_full;
			end
			REQ_ISSUE:
				o_arvalid <= keep_issuing;
			default:
				o_arvalid <= 1'b0;
			endcase
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			pending_pc <= i_pc;
	end

	// Next address to request, lane bits dropped after the first word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (ar_free)
		begin
			if (i_new_pc)
				o_araddr <= i_pc;
			else if (state == REQ_REDIRECT)
				o_araddr <= pending_pc;
			else if (o_arvalid)
				o_araddr <= {o_araddr[ADDR_WIDTH-1:LANE_W] + 1'b1, {LANE_W{1'b0}}};
		end
	end

	// AXI rule: a stalled request keeps both valid and address
	property p_araddr_hold;
		@(posedge S_AXI_ACLK) disable iff (fifo_reset)
			(o_arvalid && !i_arready) |=> (o_arvalid && $stable(o_araddr));
	endproperty

	a_araddr_hold: assert property (p_araddr_hold)
		else $error("ARADDR or ARVALID changed while AR was stalled");

endmodule

// ==== verilog/insn_fifo.sv ====
`timescale 1ns/1ps

module insn_fifo #(
	parameter int BUS_WIDTH = fetch_pkg::BUS_WIDTH_DEF,
	parameter int FETCH_LIMIT = fetch_pkg::FETCH_LIMIT_DEF
) (
	input  logic               S_AXI_ACLK,
	input  logic               i_restart,
	input  logic               i_wr,
	input  logic [BUS_WIDTH:0] i_data,
	input  logic               i_rd,
	output logic [BUS_WIDTH:0] o_data,
	output logic               o_empty
);

	localparam int PTR_W = $clog2(FETCH_LIMIT);

	// Bus word with its error flag on top
	logic [BUS_WIDTH:0] mem [FETCH_LIMIT];
	// Extra pointer bit tells full from empty
	logic [PTR_W:0]     wr_ptr;
	logic [PTR_W:0]     rd_ptr;
	logic               full;

	assign o_empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0])
		&& (wr_ptr[PTR_W] != rd_ptr[PTR_W]);

	// Head of the queue, shown before it is read
	assign o_data = mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			wr_ptr <= '0;
		else if (i_wr)
			wr_ptr <= wr_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			rd_ptr <= '0;
		else if (i_rd && !o_empty)
			rd_ptr <= rd_ptr + 1'b1;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[PTR_W-1:0]] <= i_data;
	end

	// Request throttling upstream must keep the queue from overflowing
	a_no_overflow: assert property (@(posedge S_AXI_ACLK) disable iff (i_restart)
		i_wr |-> !full)
		else $error("Write into a full instruction FIFO");

endmodule

// ==== verilog/insn_unpacker.sv ====
`timescale 1ns/1ps

module insn_unpacker #(
	parameter int ADDR_WIDTH = fetch_pkg::ADDR_WIDTH_DEF,
	parameter int BUS_WIDTH = fetch_pkg::BUS_WIDTH_DEF,
	parameter int INSN_WIDTH = fetch_pkg::INSN_WIDTH_DEF
) (
	input  logic                  S_AXI_ACLK,
	input  logic                  i_restart,
	input  logic                  i_new_pc,
	input  logic [ADDR_WIDTH-1:0] i_pc,
	input  logic                  i_ready,
	input  logic [BUS_WIDTH:0]    i_fifo_data,
	input  logic                  i_fifo_empty,
	output logic                  o_fifo_rd,
	output logic [INSN_WIDTH-1:0] o_insn,
	output logic [ADDR_WIDTH-1:0] o_pc,
	output logic                  o_valid,
	output logic                  o_illegal
);

	localparam int LANE_W = $clog2(BUS_WIDTH/8);
	localparam int INSNS_PER_WORD = BUS_WIDTH / INSN_WIDTH;
	localparam int LEFT_W = $clog2(INSNS_PER_WORD) + 1;

	logic [BUS_WIDTH-1:0] out_data;
	logic [LEFT_W-1:0]    remaining;
	logic [LANE_W-1:0]    shift;
	logic                 word_load;

	// First word after a redirect starts at the PC's slot, later ones at 0
	assign shift = o_valid ? '0 : (o_pc[LANE_W-1:0] >> 2);

	// Pull a word when empty or when the last slot is being taken
	assign o_fifo_rd = !o_illegal
		&& ((remaining == '0) || (i_ready && (remaining == 1)));
	assign word_load = o_fifo_rd && !i_fifo_empty;

	assign o_insn = out_data[INSN_WIDTH-1:0];

	//////////////////////////////////////////////////////////////////////
	// Slot count and output valid
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			remaining <= '0;
		else if (word_load)
			remaining <= LEFT_W'(INSNS_PER_WORD) - LEFT_W'(shift);
		else if (o_fifo_rd)
			remaining <= '0;
		else if (!o_illegal && i_ready && (remaining != '0))
			remaining <= remaining - 1'b1;
	end

	// A bus error freezes the output until the next restart
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			o_valid <= 1'b0;
		else if (!o_illegal && (!o_valid || i_ready))
			o_valid <= word_load || (remaining > 1);
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_restart)
			o_illegal <= 1'b0;
		else if (word_load)
			o_illegal <= i_fifo_data[BUS_WIDTH];
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction data and PC
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (word_load)
			out_data <= i_fifo_data[BUS_WIDTH-1:0] >> (INSN_WIDTH * shift);
		else if (i_ready && !o_illegal)
			out_data <= out_data >> INSN_WIDTH;
	end

	// Instructions are taken as 4 bytes each
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_new_pc)
			o_pc <= i_pc;
		else if (o_valid && i_ready && !o_illegal)
			o_pc <= {o_pc[ADDR_WIDTH-1:2] + 1'b1, 2'b00};
	end

	a_valid_count: assert property (@(posedge S_AXI_ACLK) disable iff (i_restart)
		o_valid == (remaining != '0))
		else $error("o_valid does not match the remaining slot count");

endmodule
